/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_iq_frontend -o tb_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Testbench failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"

/* sources.f */
+incdir+include
verilog/iq_pkg.sv
verilog/fetch_bundle_if.sv
verilog/queue_head_if.sv
verilog/fetch_predecode.sv
verilog/inst_queue.sv
verilog/issue_pairing.sv
verilog/iq_frontend_top.sv
testbench/tb_iq_frontend.sv

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step for every bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	int          k;
	v = '0;
	for (k = 0; k < n; k++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

task automatic check_count(input string tag, input slot_count_t exp, input slot_count_t act);
	if (exp !== act) begin
		$display("[FAIL] %s: expected %0d, actual %0d", tag, exp, act);
		value_errs++;
	end
endtask

task automatic check_pc(input string tag, input pc_t exp, input pc_t act);
	if (exp !== act) begin
		$display("[FAIL] %s: expected %08h, actual %08h", tag, exp, act);
		value_errs++;
	end
endtask

task automatic check_instr(input string tag, input instr_t exp, input instr_t act);
	if (exp !== act) begin
		$display("[FAIL] %s: expected %08h, actual %08h", tag, exp, act);
		value_errs++;
	end
endtask

task automatic check_occ(input string tag, input occ_t exp, input occ_t act);
	if (exp !== act) begin
		$display("[FAIL] %s: expected %0d, actual %0d", tag, exp, act);
		value_errs++;
	end
endtask

task automatic check_flag(input string tag, input logic exp, input logic act);
	if (exp !== act) begin
		$display("[FAIL] %s: expected %b, actual %b", tag, exp, act);
		value_errs++;
	end
endtask

`endif

/* testbench/tb_iq_frontend.sv */
`timescale 1ns/1ps

module tb_iq_frontend;
	import iq_pkg::*;

	localparam int DEPTH = 16;
	// the random stream dominates the run length
	localparam int MAX_CYCLES = 4000;

	typedef logic [$clog2(DEPTH + 1)-1:0] occ_t;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        in_valid;
	logic        in_ready;
	pc_t         in_pc;
	instr_t      in_instr0;
	instr_t      in_instr1;
	slot_count_t in_count;
	logic        out_valid;
	logic        out_ready;
	slot_count_t out_count;
	pc_t         out_pc0;
	instr_t      out_instr0;
	pc_t         out_pc1;
	instr_t      out_instr1;
	occ_t        occupancy;

	int          value_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;
	logic [31:0] lfsr_state = 32'h3a8b;
	string       test_name = "reset";
	slot_count_t want_count = 2'd0;
	logic        rand_ready = 1'b0;
	pc_t         next_pc = '0;

	// reference model of instructions sent and not yet issued
	pc_t         exp_pc [$];
	instr_t      exp_instr [$];

	opcode_t     opc_table [10] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_LOAD,
		OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, 7'b1110011};

	`include "tb_checks.svh"

	iq_frontend_top #(.depth(DEPTH)) u_dut (
		.clk(clk), .rst_n(rst_n), .flush(flush),
		.in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc),
		.in_instr0(in_instr0), .in_instr1(in_instr1), .in_count(in_count),
		.out_valid(out_valid), .out_ready(out_ready), .out_count(out_count),
		.out_pc0(out_pc0), .out_instr0(out_instr0),
		.out_pc1(out_pc1), .out_instr1(out_instr1),
		.occupancy(occupancy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic instr_t encode(input opcode_t opc, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		return {7'd0, rs2, rs1, 3'd0, rd, opc};
	endfunction

	function automatic op_class_t class_of(input instr_t i);
		case (opcode_t'(i[6:0]))
			OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: return OP_ALU;
			OPC_LOAD: return OP_LOAD;
			OPC_STORE: return OP_STORE;
			OPC_BRANCH: return OP_BRANCH;
			OPC_JAL, OPC_JALR: return OP_JUMP;
			default: return OP_SYS;
		endcase
	endfunction

	// may a and b leave in the same issue bundle
	function automatic logic can_pair(input instr_t a, input instr_t b);
		op_class_t ca;
		op_class_t cb;
		reg_idx_t  rd_a;
		reg_idx_t  rs1_b;
		reg_idx_t  rs2_b;
		ca    = class_of(a);
		cb    = class_of(b);
		rd_a  = (ca == OP_STORE || ca == OP_BRANCH) ? 5'd0 : a[11:7];
		rs1_b = (b[6:0] == OPC_LUI || b[6:0] == OPC_AUIPC || b[6:0] == OPC_JAL) ?
			5'd0 : b[19:15];
		rs2_b = (cb == OP_STORE || cb == OP_BRANCH || b[6:0] == OPC_OP) ? b[24:20] : 5'd0;
		if (ca == OP_BRANCH || ca == OP_JUMP) return 1'b0;
		if (rd_a != 5'd0 && (rd_a == rs1_b || rd_a == rs2_b)) return 1'b0;
		if ((ca == OP_LOAD || ca == OP_STORE) && (cb == OP_LOAD || cb == OP_STORE)) return 1'b0;
		return 1'b1;
	endfunction

	function automatic instr_t rand_word();
		logic [3:0] sel;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		sel = 4'(rand_bits(4) % 32'd10);
		// three-bit register fields so dependencies come up often
		rd  = reg_idx_t'(rand_bits(3));
		rs1 = reg_idx_t'(rand_bits(3));
		rs2 = reg_idx_t'(rand_bits(3));
		return encode(opc_table[sel], rd, rs1, rs2);
	endfunction

	task automatic check_issue();
		if (exp_pc.size() == 0) begin
			$display("%s: issue bundle came out with nothing outstanding", test_name);
			other_errs++;
		end else begin
			check_pc({test_name, " pc0"}, exp_pc[0], out_pc0);
			check_instr({test_name, " instr0"}, exp_instr[0], out_instr0);
			if (want_count != 2'd0) check_count({test_name, " count"}, want_count, out_count);
			if (out_count == 2'd2 && exp_pc.size() < 2) begin
				$display("%s: pair issued with only one instruction outstanding", test_name);
				other_errs++;
				void'(exp_pc.pop_front());
				void'(exp_instr.pop_front());
			end else if (out_count == 2'd2) begin
				if (!can_pair(exp_instr[0], exp_instr[1])) begin
					$display("%s: pair issued together against the pairing rule", test_name);
					other_errs++;
				end
				check_pc({test_name, " pc1"}, exp_pc[1], out_pc1);
				check_instr({test_name, " instr1"}, exp_instr[1], out_instr1);
				repeat (2) void'(exp_pc.pop_front());
				repeat (2) void'(exp_instr.pop_front());
			end else begin
				check_pc({test_name, " pc1 of single"}, '0, out_pc1);
				check_instr({test_name, " instr1 of single"}, '0, out_instr1);
				void'(exp_pc.pop_front());
				void'(exp_instr.pop_front());
			end
		end
	endtask

	// both handshakes observed on the same edge the DUT sees them
	always @(posedge clk) begin
		if (!rst_n || flush) begin
			exp_pc.delete();
			exp_instr.delete();
		end else begin
			if (out_valid && out_ready) check_issue();
			if (in_valid && in_ready) begin
				exp_pc.push_back(in_pc);
				exp_instr.push_back(in_instr0);
				if (in_count == 2'd2) begin
					exp_pc.push_back(in_pc + 32'd4);
					exp_instr.push_back(in_instr1);
				end
			end
		end
	end

	task automatic send_bundle(input instr_t i0, input instr_t i1, input slot_count_t cnt);
		in_valid  = 1'b1;
		in_pc     = next_pc;
		in_instr0 = i0;
		in_instr1 = (cnt == 2'd2) ? i1 : '0;
		in_count  = cnt;
		next_pc   = next_pc + ((cnt == 2'd2) ? 32'd8 : 32'd4);
		if (rand_ready) out_ready = rand_bits(1) != 32'd0;
		@(negedge clk);
		while (!in_ready) begin
			@(posedge clk);
			#1;
			if (rand_ready) out_ready = rand_bits(1) != 32'd0;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_pc.size() != 0) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic send_pair(input instr_t i0, input instr_t i1);
		want_count = can_pair(i0, i1) ? 2'd2 : 2'd1;
		send_bundle(i0, i1, 2'd2);
		wait_drain();
		want_count = 2'd0;
	endtask

	task automatic single_stream();
		int i;
		test_name  = "single_stream";
		next_pc    = 32'h0000_1000;
		want_count = 2'd1;
		for (i = 1; i < 9; i++) begin
			send_bundle(encode(OPC_OP_IMM, reg_idx_t'(i), 5'd0, 5'd0), '0, 2'd1);
			// predecode, queue, then the issue register
			repeat (2) @(posedge clk);
			#1;
			check_flag({test_name, " latency"}, 1'b1, out_valid);
			wait_drain();
		end
		want_count = 2'd0;
	endtask

	task automatic pairing_rule();
		test_name = "pairing_rule";
		next_pc   = 32'h0000_2000;
		send_pair(encode(OPC_OP_IMM, 5'd1, 5'd0, 5'd0), encode(OPC_OP, 5'd2, 5'd3, 5'd4));
		send_pair(encode(OPC_OP_IMM, 5'd5, 5'd0, 5'd0), encode(OPC_OP, 5'd6, 5'd5, 5'd7));
		send_pair(encode(OPC_BRANCH, 5'd0, 5'd1, 5'd2), encode(OPC_OP_IMM, 5'd8, 5'd0, 5'd0));
		send_pair(encode(OPC_LOAD, 5'd9, 5'd1, 5'd0), encode(OPC_LOAD, 5'd10, 5'd2, 5'd0));
		// x0 as destination carries no dependency
		send_pair(encode(OPC_OP_IMM, 5'd0, 5'd1, 5'd0), encode(OPC_OP, 5'd11, 5'd0, 5'd0));
	endtask

	task automatic back_pressure();
		int sent;
		test_name = "back_pressure";
		next_pc   = 32'h0000_3000;
		out_ready = 1'b0;
		sent      = 0;
		while (in_ready && sent < 24) begin
			send_bundle(encode(OPC_OP_IMM, 5'd1, 5'd2, 5'd0), encode(OPC_OP, 5'd3, 5'd4, 5'd5),
				2'd2);
			sent++;
		end
		repeat (3) @(posedge clk);
		#1;
		check_flag({test_name, " in_ready"}, 1'b0, in_ready);
		if (occupancy < occ_t'(DEPTH - 2)) begin
			$display("%s: queue held only %0d entries while stalled", test_name, occupancy);
			other_errs++;
		end
		out_ready = 1'b1;
		wait_drain();
	endtask

	task automatic flush_recovery();
		int sent;
		test_name = "flush_recovery";
		next_pc   = 32'h0000_4000;
		out_ready = 1'b0;
		sent      = 0;
		// every stage holds data when the flush hits
		while (in_ready && sent < 24) begin
			send_bundle(encode(OPC_OP_IMM, 5'd12, 5'd0, 5'd0),
				encode(OPC_OP_IMM, 5'd13, 5'd0, 5'd0), 2'd2);
			sent++;
		end
		check_flag({test_name, " in_ready before flush"}, 1'b0, in_ready);
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		check_flag({test_name, " out_valid"}, 1'b0, out_valid);
		check_occ({test_name, " occupancy"}, '0, occupancy);
		check_flag({test_name, " in_ready"}, 1'b1, in_ready);
		out_ready = 1'b1;
		next_pc   = 32'h0000_5000;
		send_bundle(encode(OPC_OP_IMM, 5'd14, 5'd0, 5'd0), '0, 2'd1);
		send_bundle(encode(OPC_OP_IMM, 5'd15, 5'd0, 5'd0), '0, 2'd1);
		wait_drain();
	endtask

	task automatic random_stream();
		int          i;
		slot_count_t cnt;
		instr_t      i0;
		instr_t      i1;
		test_name  = "random_stream";
		next_pc    = 32'h0001_0000;
		rand_ready = 1'b1;
		for (i = 0; i < 200; i++) begin
			cnt = (rand_bits(1) != 32'd0) ? 2'd2 : 2'd1;
			i0  = rand_word();
			i1  = rand_word();
			send_bundle(i0, i1, cnt);
		end
		rand_ready = 1'b0;
		out_ready  = 1'b1;
		wait_drain();
	endtask

	initial begin
		rst_n     = 1'b0;
		flush     = 1'b0;
		in_valid  = 1'b0;
		in_pc     = '0;
		in_instr0 = '0;
		in_instr1 = '0;
		in_count  = 2'd1;
		out_ready = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		single_stream();
		pairing_rule();
		back_pressure();
		flush_recovery();
		random_stream();
		$display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verilog/fetch_bundle_if.sv */
`timescale 1ns/1ps

interface fetch_bundle_if;
	import iq_pkg::*;

	// predecoded bundle from predecode to the queue
	logic        valid;
	logic        ready;
	slot_count_t count;
	iq_entry_t   e0;
	iq_entry_t   e1;

	modport producer (
		output valid,
		output count,
		output e0,
		output e1,
		input  ready
	);

	modport consumer (
		input  valid,
		input  count,
		input  e0,
		input  e1,
		output ready
	);

endinterface

/* verilog/fetch_predecode.sv */
`timescale 1ns/1ps

module fetch_predecode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                in_valid,
	output logic                in_ready,
	input  iq_pkg::pc_t         in_pc,
	input  iq_pkg::instr_t      in_instr0,
	input  iq_pkg::instr_t      in_instr1,
	input  iq_pkg::slot_count_t in_count,
	fetch_bundle_if.producer    bundle
);
	import iq_pkg::*;

	logic        valid_q;
	slot_count_t count_q;
	iq_entry_t   e0_q;
	iq_entry_t   e1_q;

	// opcode to class and operand fields
	function automatic iq_entry_t decode(input pc_t pc, input instr_t instr);
		iq_entry_t e;
		e.pc       = pc;
		e.instr    = instr;
		e.op_class = OP_SYS;
		e.rd       = instr[11:7];
		e.rs1      = instr[19:15];
		e.rs2      = '0;
		case (opcode_t'(instr[6:0]))
			OPC_OP: begin
				e.op_class = OP_ALU;
				e.rs2      = instr[24:20];
			end
			OPC_OP_IMM: e.op_class = OP_ALU;
			OPC_LUI, OPC_AUIPC: begin
				e.op_class = OP_ALU;
				e.rs1      = '0;
			end
			OPC_LOAD: e.op_class = OP_LOAD;
			OPC_STORE: begin
				e.op_class = OP_STORE;
				e.rd       = '0;
				e.rs2      = instr[24:20];
			end
			OPC_BRANCH: begin
				e.op_class = OP_BRANCH;
				e.rd       = '0;
				e.rs2      = instr[24:20];
			end
			OPC_JAL: begin
				e.op_class = OP_JUMP;
				e.rs1      = '0;
			end
			OPC_JALR: e.op_class = OP_JUMP;
			default: e.op_class = OP_SYS;
		endcase
		return e;
	endfunction

	// one-deep holding register, refills in the cycle it drains
	assign in_ready = !valid_q || bundle.ready;

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			count_q <= in_count;
			e0_q    <= decode(in_pc, in_instr0);
			// second word is always the next sequential one
			e1_q    <= decode(in_pc + PC_STEP, in_instr1);
		end
	end

	assign bundle.valid = valid_q;
	assign bundle.count = count_q;
	assign bundle.e0    = e0_q;
	assign bundle.e1    = e1_q;

	// fetch only ever hands over one or two words
	a_in_count: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (in_count == 2'd1 || in_count == 2'd2));

endmodule

/* verilog/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
	parameter int depth = iq_pkg::IQ_DEPTH_DEFAULT
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	fetch_bundle_if.consumer             enq_side,
	queue_head_if.source                 head,
	output logic [$clog2(depth + 1)-1:0] occupancy
);
	import iq_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [cnt_w-1:0] cnt_t;

	// entry storage, no reset
	iq_entry_t mem [depth];

	ptr_t        rd_ptr;
	ptr_t        wr_ptr;
	cnt_t        count_q;
	cnt_t        free_slots;
	logic        enq_fire;
	slot_count_t enq_n;

	// pointer advance with wrap at depth, which need not be a power of two
	function automatic ptr_t ptr_add(input ptr_t p, input slot_count_t n);
		logic [ptr_w:0] sum;
		sum = {1'b0, p} + (ptr_w + 1)'(n);
		if (sum >= (ptr_w + 1)'(depth)) begin
			sum = sum - (ptr_w + 1)'(depth);
		end
		return sum[ptr_w-1:0];
	endfunction

	assign free_slots = cnt_t'(depth) - count_q;

	// ready looks only at free space, never at valid
	assign enq_side.ready = free_slots >= cnt_t'(enq_side.count);

	assign enq_fire = enq_side.valid && enq_side.ready;
	assign enq_n    = enq_fire ? enq_side.count : 2'd0;

	// pointers and count, flush wins over any transfer
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			count_q <= '0;
		end else begin
			wr_ptr  <= ptr_add(wr_ptr, enq_n);
			rd_ptr  <= ptr_add(rd_ptr, head.take);
			count_q <= count_q + cnt_t'(enq_n) - cnt_t'(head.take);
		end
	end

	// storage write
	// stale entries behind a flush are never read, the pointers move past them
	always_ff @(posedge clk) begin
		if (enq_fire) begin
			mem[wr_ptr] <= enq_side.e0;
			if (enq_side.count == 2'd2) begin
				mem[ptr_add(wr_ptr, 2'd1)] <= enq_side.e1;
			end
		end
	end

	// head view straight from storage
	// an entry written on an edge shows up only after it
	assign head.head0 = mem[rd_ptr];
	assign head.head1 = mem[ptr_add(rd_ptr, 2'd1)];

	always_comb begin
		if (count_q >= cnt_t'(2)) begin
			head.avail = 2'd2;
		end else begin
			head.avail = slot_count_t'(count_q);
		end
	end

	assign occupancy = count_q;

	// the pairing stage must not ask for more than the head shows
	a_take_le_avail: assert property (@(posedge clk) disable iff (!rst_n)
		head.take <= head.avail);

	// enqueue handshake and dequeue together never overfill
	a_occ_le_depth: assert property (@(posedge clk) disable iff (!rst_n)
		count_q <= cnt_t'(depth));

endmodule

/* verilog/iq_frontend_top.sv */
`timescale 1ns/1ps

module iq_frontend_top #(
	parameter int depth = iq_pkg::IQ_DEPTH_DEFAULT
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,

	// raw words from fetch
	input  logic                         in_valid,
	output logic                         in_ready,
	input  iq_pkg::pc_t                  in_pc,
	input  iq_pkg::instr_t               in_instr0,
	input  iq_pkg::instr_t               in_instr1,
	input  iq_pkg::slot_count_t          in_count,

	// issue bundles
	output logic                         out_valid,
	input  logic                         out_ready,
	output iq_pkg::slot_count_t          out_count,
	output iq_pkg::pc_t                  out_pc0,
	output iq_pkg::instr_t               out_instr0,
	output iq_pkg::pc_t                  out_pc1,
	output iq_pkg::instr_t               out_instr1,

	output logic [$clog2(depth + 1)-1:0] occupancy
);

	fetch_bundle_if bundle_if ();
	queue_head_if   head_if ();

	// decode, store, then pair for issue
	fetch_predecode u_predecode (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pc     (in_pc),
		.in_instr0 (in_instr0),
		.in_instr1 (in_instr1),
		.in_count  (in_count),
		.bundle    (bundle_if.producer)
	);

	inst_queue #(
		.depth (depth)
	) u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.enq_side  (bundle_if.consumer),
		.head      (head_if.source),
		.occupancy (occupancy)
	);

	issue_pairing u_pairing (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.head       (head_if.sink),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_count  (out_count),
		.out_pc0    (out_pc0),
		.out_pc1    (out_pc1),
		.out_instr0 (out_instr0),
		.out_instr1 (out_instr1)
	);

endmodule

/* verilog/iq_pkg.sv */
package iq_pkg;

	// basic widths
	typedef logic [31:0] pc_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	// entries in one transfer, 0 to 2
	typedef logic [1:0]  slot_count_t;

	// operation classes
	typedef logic [2:0]  op_class_t;

	localparam op_class_t OP_ALU    = 3'd0;
	localparam op_class_t OP_LOAD   = 3'd1;
	localparam op_class_t OP_STORE  = 3'd2;
	localparam op_class_t OP_BRANCH = 3'd3;
	localparam op_class_t OP_JUMP   = 3'd4;
	localparam op_class_t OP_SYS    = 3'd5;

	// rv32i major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	// one queue entry
	// rd, rs1 and rs2 are zero where the instruction has no such operand
	typedef struct packed {
		pc_t       pc;
		instr_t    instr;
		op_class_t op_class;
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
	} iq_entry_t;

	// default queue depth
	localparam int IQ_DEPTH_DEFAULT = 16;

	// offset of the second word of a fetch pair
	localparam pc_t PC_STEP = 32'd4;

endpackage

/* verilog/issue_pairing.sv */
`timescale 1ns/1ps

module issue_pairing (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,
	queue_head_if.sink          head,
	output logic                out_valid,
	input  logic                out_ready,
	output iq_pkg::slot_count_t out_count,
	output iq_pkg::pc_t         out_pc0,
	output iq_pkg::pc_t         out_pc1,
	output iq_pkg::instr_t      out_instr0,
	output iq_pkg::instr_t      out_instr1
);
	import iq_pkg::*;

	logic        valid_q;
	logic        can_load;
	logic        h0_ctrl;
	logic        h0_mem;
	logic        h1_mem;
	logic        raw_dep;
	logic        pair_ok;
	slot_count_t take_n;

	// register free now or emptied on this edge
	assign can_load = !valid_q || out_ready;

	assign h0_ctrl = head.head0.op_class == OP_BRANCH || head.head0.op_class == OP_JUMP;
	assign h0_mem  = head.head0.op_class == OP_LOAD || head.head0.op_class == OP_STORE;
	assign h1_mem  = head.head1.op_class == OP_LOAD || head.head1.op_class == OP_STORE;

	// x0 never carries a dependency
	assign raw_dep = (head.head0.rd != '0) &&
		(head.head0.rd == head.head1.rs1 || head.head0.rd == head.head1.rs2);

	// one memory port, control ends the group
	assign pair_ok = (head.avail == 2'd2) && !h0_ctrl && !raw_dep && !(h0_mem && h1_mem);

	always_comb begin
		take_n = 2'd0;
		if (can_load && head.avail != 2'd0) begin
			take_n = pair_ok ? 2'd2 : 2'd1;
		end
	end

	assign head.take = take_n;

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			valid_q <= 1'b0;
		end else if (can_load) begin
			valid_q <= head.avail != 2'd0;
		end
	end

	// issue payload
	always_ff @(posedge clk) begin
		if (take_n != 2'd0) begin
			out_count  <= take_n;
			out_pc0    <= head.head0.pc;
			out_instr0 <= head.head0.instr;
			// slot 1 reads as zero for a single issue
			out_pc1    <= pair_ok ? head.head1.pc : '0;
			out_instr1 <= pair_ok ? head.head1.instr : '0;
		end
	end

	assign out_valid = valid_q;

	// a single or a pair, never an empty bundle on the bus
	a_out_count: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_count == 2'd1 || out_count == 2'd2));

endmodule

/* verilog/queue_head_if.sv */
`timescale 1ns/1ps

interface queue_head_if;
	import iq_pkg::*;

	// two oldest entries plus how many of them are real
	iq_entry_t   head0;
	iq_entry_t   head1;
	slot_count_t avail;

	// entries removed on the next edge
	slot_count_t take;

	modport source (
		output head0,
		output head1,
		output avail,
		input  take
	);

	modport sink (
		input  head0,
		input  head1,
		input  avail,
		output take
	);

endinterface
